//--- compile.f
+incdir+hdl
hdl/pixel_pkg.sv
hdl/wb_pkg.sv
hdl/pixel_stream_if.sv
hdl/blob_if.sv
hdl/seq_divider.sv
hdl/color_classifier.sv
hdl/group_detection.sv
hdl/blob_regs.sv
hdl/blob_tracker_top.sv
testbench/tb_blob_tracker.sv

//--- hdl/blob_if.sv
`default_nettype none

// one detection result per frame
interface blob_if;

    logic              valid; // single-cycle strobe
    logic              present;
    pixel_pkg::coord_t row;
    pixel_pkg::coord_t col;

    modport source (
        output valid, present, row, col
    );

    modport sink (
        input valid, present, row, col
    );

endinterface

`default_nettype wire

//--- hdl/blob_params.svh
`ifndef BLOB_PARAMS_SVH
`define BLOB_PARAMS_SVH

// raster size, fixed at build time
`define FRAME_W 640
`define FRAME_H 480

// classifier defaults
`define RED_THRESH_DEFAULT 10
`define BG_MAX 5 // max green/blue nibble for a red pixel

// detection limits
`define MIN_ROW_RED 6   // red pixels for an active row
`define MIN_ACT_ROWS 6  // active rows for a present object
`define BEST_ROW_MIN 10 // a best row must beat this count

`define DIV_W 19 // divider and accumulator width

`endif

//--- hdl/blob_regs.sv
`include "blob_params.svh"
`default_nettype none

module blob_regs (
    input  wire logic            iCLK,
    input  wire logic            iRST,
    input  wire logic            cyc,
    input  wire logic            stb,
    input  wire logic            we,
    input  wire wb_pkg::wb_adr_t adr,
    input  wire wb_pkg::wb_dat_t dat_w,
    output wb_pkg::wb_dat_t      dat_r,
    output logic                 ack,
    blob_if.sink                 blob,
    output pixel_pkg::nibble_t   thresh
);

    localparam int NIB_W = $bits(pixel_pkg::nibble_t);

    logic              req;       // new access, not yet acked
    logic              rd_status;
    logic              new_flag;  // sticky until STATUS is read
    logic              present_r;
    pixel_pkg::coord_t row_r, col_r;
    wb_pkg::wb_dat_t   frames_r;
    wb_pkg::wb_dat_t   rd_data;

    assign req       = cyc && stb && !ack;
    assign rd_status = req && !we && (adr == wb_pkg::STATUS);

    always_comb begin
        case (adr)
            wb_pkg::STATUS: rd_data = {30'd0, new_flag, present_r};
            wb_pkg::ROW:    rd_data = wb_pkg::wb_dat_t'(row_r);
            wb_pkg::COL:    rd_data = wb_pkg::wb_dat_t'(col_r);
            wb_pkg::FRAMES: rd_data = frames_r;
            wb_pkg::THRESH: rd_data = wb_pkg::wb_dat_t'(thresh);
            default:        rd_data = '0; // unmapped
        endcase
    end

    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            ack       <= 1'b0;
            new_flag  <= 1'b0;
            present_r <= 1'b0;
            row_r     <= '0;
            col_r     <= '0;
            frames_r  <= '0;
            thresh    <= pixel_pkg::nibble_t'(`RED_THRESH_DEFAULT);
        end else begin
            ack <= req;
            if (blob.valid) begin
                row_r     <= blob.row;
                col_r     <= blob.col;
                present_r <= blob.present;
                frames_r  <= frames_r + 1'b1;
                new_flag  <= 1'b1; // wins over a clearing read
            end else if (rd_status) begin
                new_flag <= 1'b0;
            end
            if (req && we && adr == wb_pkg::THRESH)
                thresh <= dat_w[NIB_W-1:0];
        end
    end

    // read data captured with ack, held only while ack is high
    always_ff @(posedge iCLK) begin
        if (req)
            dat_r <= rd_data;
    end

    a_ack_single : assert property (
        @(posedge iCLK) disable iff (!iRST)
        ack |=> !ack
    ) else $error("ack held for two cycles");

endmodule

`default_nettype wire

//--- hdl/blob_tracker_top.sv
`default_nettype none

module blob_tracker_top (
    input  wire logic              iCLK,
    input  wire logic              iRST,
    input  wire pixel_pkg::color_t color,
    input  wire logic              dval,
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire wb_pkg::wb_adr_t   wb_adr,
    input  wire wb_pkg::wb_dat_t   wb_dat_w,
    output wb_pkg::wb_dat_t        wb_dat_r,
    output logic                   wb_ack
);

    pixel_pkg::nibble_t thresh; // from the register file

    pixel_stream_if pix_bus ();
    blob_if         blob_bus ();

    color_classifier color_classifier_inst (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .color  (color),
        .dval   (dval),
        .thresh (thresh),
        .pix    (pix_bus.source)
    );

    // grouping and centroid division
    group_detection group_detection_inst (
        .iCLK (iCLK),
        .iRST (iRST),
        .pix  (pix_bus.sink),
        .blob (blob_bus.source)
    );

    blob_regs blob_regs_inst (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .cyc    (wb_cyc),
        .stb    (wb_stb),
        .we     (wb_we),
        .adr    (wb_adr),
        .dat_w  (wb_dat_w),
        .dat_r  (wb_dat_r),
        .ack    (wb_ack),
        .blob   (blob_bus.sink),
        .thresh (thresh)
    );

endmodule

`default_nettype wire

//--- hdl/color_classifier.sv
`include "blob_params.svh"
`default_nettype none

module color_classifier (
    input  wire logic               iCLK,
    input  wire logic               iRST,
    input  wire pixel_pkg::color_t  color,
    input  wire logic               dval,
    input  wire pixel_pkg::nibble_t thresh,
    pixel_stream_if.source          pix
);

    localparam pixel_pkg::coord_t LAST_COL = pixel_pkg::coord_t'(`FRAME_W - 1);
    localparam pixel_pkg::coord_t LAST_ROW = pixel_pkg::coord_t'(`FRAME_H - 1);

    pixel_pkg::nibble_t r_n, g_n, b_n;
    pixel_pkg::coord_t  col_cnt;  // position of the incoming pixel
    pixel_pkg::coord_t  row_cnt;
    logic               is_red;

    assign r_n = color[11:8];
    assign g_n = color[7:4];
    assign b_n = color[3:0];

    // strong red with little green and blue
    assign is_red = (r_n >= thresh)
                 && (g_n <= pixel_pkg::nibble_t'(`BG_MAX))
                 && (b_n <= pixel_pkg::nibble_t'(`BG_MAX));

    // raster counters, advance on valid pixels only
    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            pix.dval <= 1'b0;
        end else begin
            pix.dval <= dval;
            if (dval) begin
                if (col_cnt == LAST_COL) begin
                    col_cnt <= '0;
                    row_cnt <= (row_cnt == LAST_ROW) ? '0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iCLK) begin
        if (dval) begin
            pix.red <= is_red;
            pix.col <= col_cnt; // position of this pixel, not the next
            pix.row <= row_cnt;
        end
    end

    a_col_range : assert property (
        @(posedge iCLK) disable iff (!iRST)
        pix.dval |-> (pix.col < pixel_pkg::coord_t'(`FRAME_W))
    ) else $error("column out of frame: %0d", pix.col);

endmodule

`default_nettype wire

//--- hdl/group_detection.sv
`include "blob_params.svh"
`default_nettype none

module group_detection (
    input  wire logic     iCLK,
    input  wire logic     iRST,
    pixel_stream_if.sink  pix,
    blob_if.source        blob
);

    localparam int CRD_W = $bits(pixel_pkg::coord_t);

    typedef enum logic [1:0] {IDLE, DIV_COL, DIV_ROW, DONE} state_e;

    state_e state;

    logic row_end, frame_end, first_row;
    logic row_active, better;

    // current row
    pixel_pkg::count_t row_cnt, cnt_base, cnt_nx;
    pixel_pkg::sum_t   row_csum, csum_base, csum_nx;

    // current frame
    pixel_pkg::count_t act_rows, act_base, act_nx;
    pixel_pkg::sum_t   rsum, rsum_base, rsum_nx;
    pixel_pkg::count_t best_cnt, bcnt_base, bcnt_nx;
    pixel_pkg::sum_t   best_sum, bsum_base, bsum_nx;

    // frame totals held for the divider
    pixel_pkg::sum_t   snap_csum, snap_rsum;
    pixel_pkg::count_t snap_ccnt, snap_acnt;
    logic              snap_present;

    logic            div_start, div_done;
    pixel_pkg::sum_t div_dividend, div_divisor, div_quot;

    assign row_end   = pix.dval && (pix.col == pixel_pkg::coord_t'(`FRAME_W - 1));
    assign frame_end = row_end && (pix.row == pixel_pkg::coord_t'(`FRAME_H - 1));
    assign first_row = (pix.row == '0);

    // next values include the pixel now on the bus
    always_comb begin
        cnt_base  = (pix.col == '0) ? '0 : row_cnt;
        csum_base = (pix.col == '0) ? '0 : row_csum;
        cnt_nx    = cnt_base + pixel_pkg::count_t'(pix.red);
        csum_nx   = pix.red ? csum_base + pixel_pkg::sum_t'(pix.col) : csum_base;

        // row 0 restarts the frame totals
        act_base  = first_row ? '0 : act_rows;
        rsum_base = first_row ? '0 : rsum;
        bcnt_base = first_row ? pixel_pkg::count_t'(`BEST_ROW_MIN) : best_cnt;
        bsum_base = first_row ? '0 : best_sum;

        row_active = (cnt_nx >= pixel_pkg::count_t'(`MIN_ROW_RED));
        act_nx     = act_base + pixel_pkg::count_t'(row_active);
        rsum_nx    = row_active ? rsum_base + pixel_pkg::sum_t'(pix.row) : rsum_base;

        better  = (cnt_nx > bcnt_base); // ties keep the earlier row
        bcnt_nx = better ? cnt_nx : bcnt_base;
        bsum_nx = better ? csum_nx : bsum_base;
    end

    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            row_cnt  <= '0;
            row_csum <= '0;
            act_rows <= '0;
            rsum     <= '0;
            best_cnt <= '0;
            best_sum <= '0;
        end else if (pix.dval) begin
            row_cnt  <= cnt_nx;
            row_csum <= csum_nx;
            if (row_end) begin
                act_rows <= act_nx;
                rsum     <= rsum_nx;
                best_cnt <= bcnt_nx;
                best_sum <= bsum_nx;
            end
        end
    end

    // next frame may accumulate while these are divided
    always_ff @(posedge iCLK) begin
        if (frame_end) begin
            snap_csum    <= bsum_nx;
            snap_ccnt    <= bcnt_nx;
            snap_rsum    <= rsum_nx;
            snap_acnt    <= act_nx;
            snap_present <= (act_nx >= pixel_pkg::count_t'(`MIN_ACT_ROWS));
        end
    end

    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            state     <= IDLE;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (frame_end) begin
                        state     <= DIV_COL;
                        div_start <= 1'b1; // operands valid next cycle
                    end
                end
                DIV_COL: begin
                    if (div_done) begin
                        state     <= DIV_ROW;
                        div_start <= 1'b1;
                    end
                end
                DIV_ROW: begin
                    if (div_done)
                        state <= DONE;
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign div_dividend = (state == DIV_ROW) ? snap_rsum : snap_csum;
    assign div_divisor  = (state == DIV_ROW) ? pixel_pkg::sum_t'(snap_acnt)
                                             : pixel_pkg::sum_t'(snap_ccnt);

    seq_divider seq_divider_inst (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .quotient (div_quot),
        .done     (div_done)
    );

    // a zero divisor forces 0
    always_ff @(posedge iCLK) begin
        if (state == DIV_COL && div_done)
            blob.col <= (snap_ccnt == '0) ? '0 : div_quot[CRD_W-1:0];
        if (state == DIV_ROW && div_done) begin
            blob.row     <= (snap_acnt == '0) ? '0 : div_quot[CRD_W-1:0];
            blob.present <= snap_present;
        end
    end

    assign blob.valid = (state == DONE);

    a_frame_idle : assert property (
        @(posedge iCLK) disable iff (!iRST)
        frame_end |-> (state == IDLE)
    ) else $error("frame end while division still running");

endmodule

`default_nettype wire

//--- hdl/pixel_pkg.sv
`include "blob_params.svh"
`default_nettype none

package pixel_pkg;

    // 4:4:4 rgb, red in the top nibble
    typedef logic [11:0] color_t;

    typedef logic [3:0] nibble_t;

    // raster row or column
    typedef logic [10:0] coord_t;

    // pixel counts per row, active rows per frame
    typedef logic [9:0] count_t;

    // column and row sums, sized to the divider
    typedef logic [`DIV_W-1:0] sum_t;

endpackage

`default_nettype wire

//--- hdl/pixel_stream_if.sv
`default_nettype none

// classified pixel with its raster position
interface pixel_stream_if;

    logic              dval;
    logic              red;
    pixel_pkg::coord_t col;
    pixel_pkg::coord_t row;

    modport source (
        output dval, red, col, row
    );

    modport sink (
        input dval, red, col, row
    );

endinterface

`default_nettype wire

//--- hdl/seq_divider.sv
`include "blob_params.svh"
`default_nettype none

module seq_divider (
    input  wire logic            iCLK,
    input  wire logic            iRST,
    input  wire logic            start,
    input  wire pixel_pkg::sum_t dividend,
    input  wire pixel_pkg::sum_t divisor,
    output pixel_pkg::sum_t      quotient,
    output logic                 done
);

    localparam int CW = $clog2(`DIV_W + 1);

    logic [CW-1:0]     steps;    // quotient bits still to go
    logic              busy;
    logic [`DIV_W-1:0] rem;
    pixel_pkg::sum_t   dvsr;
    logic [`DIV_W:0]   shifted;  // remainder plus next dividend bit
    logic [`DIV_W+1:0] diff;     // msb is the borrow

    assign shifted = {rem, quotient[`DIV_W-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvsr};

    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            busy  <= 1'b0;
            steps <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0; // single-cycle pulse
            if (start) begin
                busy  <= 1'b1;
                steps <= CW'(`DIV_W);
            end else if (busy) begin
                steps <= steps - 1'b1;
                if (steps == CW'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // dividend shifts out the top while quotient bits shift in
    always_ff @(posedge iCLK) begin
        if (start) begin
            rem      <= '0;
            dvsr     <= divisor;
            quotient <= dividend;
        end else if (busy) begin
            if (diff[`DIV_W+1]) begin // negative trial, restore
                rem      <= shifted[`DIV_W-1:0];
                quotient <= {quotient[`DIV_W-2:0], 1'b0};
            end else begin
                rem      <= diff[`DIV_W-1:0];
                quotient <= {quotient[`DIV_W-2:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [2:0] wb_adr_t; // word address
    typedef logic [31:0] wb_dat_t;

    // register map
    typedef enum wb_adr_t {
        STATUS = 3'd0, // bit 0 present, bit 1 new
        ROW    = 3'd1,
        COL    = 3'd2,
        FRAMES = 3'd3,
        THRESH = 3'd4  // the only writable one
    } reg_addr_e;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the blob tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_blob_tracker -o sim_blob_tracker

./obj_dir/sim_blob_tracker | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/tb_blob_tracker.sv
`include "blob_params.svh"
`default_nettype none

module tb_blob_tracker;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CASES     = 7;
    localparam int ACK_TIMEOUT = 20;  // cycles per bus access
    localparam int POLL_LIMIT  = 200; // status reads per frame

    // one frame of stimulus, bounds of -1 mean no rectangle
    typedef struct packed {
        int         r0;
        int         r1;
        int         c0;
        int         c1;
        logic [3:0] red_nib;
        int         thr_wr;      // threshold written before the frame, -1 for none
        logic       exp_present;
        int         exp_row;
        int         exp_col;
    } frame_case_t;

    logic              iCLK;
    logic              iRST;
    pixel_pkg::color_t color;
    logic              dval;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    wb_pkg::wb_adr_t   wb_adr;
    wb_pkg::wb_dat_t   wb_dat_w;
    wb_pkg::wb_dat_t   wb_dat_r;
    logic              wb_ack;

    logic [31:0]       rng; // xorshift state
    frame_case_t       cases [N_CASES];

    blob_tracker_top blob_tracker_top_inst (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .color    (color),
        .dval     (dval),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        iCLK = 1'b0;
        forever #10 iCLK = ~iCLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one classic cycle, request held until ack
    task automatic bus_access(input wb_pkg::wb_adr_t adr, input logic we,
                              input wb_pkg::wb_dat_t wdat, output wb_pkg::wb_dat_t rdat);
        int waited;
        waited = 0;
        @(negedge iCLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge iCLK);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        if (!wb_ack) begin
            $display("timeout: the bus gave no ack for address %0d", adr);
            abort_run();
        end else begin
            rdat   = wb_dat_r; // valid while ack is high
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic bus_read(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t data);
        bus_access(adr, 1'b0, '0, data);
    endtask

    task automatic bus_write(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t data);
        wb_pkg::wb_dat_t unused;
        bus_access(adr, 1'b1, data, unused);
    endtask

    // full raster, one valid pixel per clock
    task automatic stream_frame(input int idx);
        logic in_rect;
        for (int r = 0; r < `FRAME_H; r++) begin
            for (int c = 0; c < `FRAME_W; c++) begin
                @(negedge iCLK);
                in_rect = (r >= cases[idx].r0) && (r <= cases[idx].r1)
                       && (c >= cases[idx].c0) && (c <= cases[idx].c1);
                rng   = xorshift32(rng);
                dval  = 1'b1;
                // background red nibble kept below 8
                color = in_rect ? {cases[idx].red_nib, 8'h00} : (rng[11:0] & 12'h7FF);
            end
        end
        @(negedge iCLK);
        dval = 1'b0;
    endtask

    task automatic wait_for_result(input int idx, output wb_pkg::wb_dat_t status);
        int polls;
        polls = 0;
        bus_read(wb_pkg::STATUS, status);
        while (!status[1] && polls < POLL_LIMIT) begin
            bus_read(wb_pkg::STATUS, status);
            polls++;
        end
        if (!status[1]) begin
            $display("timeout: no new result after frame %0d", idx);
            abort_run();
        end
    endtask

    initial begin
        wb_pkg::wb_dat_t rd;
        iRST     = 1'b0;
        dval     = 1'b0;
        color    = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rng      = 32'd91278;

        // r0 r1 c0 c1 nibble thr_wr present row col
        cases[0] = '{100, 119, 200, 239, 4'hF, -1, 1'b1, 109, 219};
        cases[1] = '{470, 479, 600, 639, 4'hC, -1, 1'b1, 474, 619}; // ends on last pixel
        cases[2] = '{0, 5, 0, 15, 4'hA, -1, 1'b1, 2, 7};            // six rows, at threshold
        cases[3] = '{300, 303, 50, 99, 4'hF, -1, 1'b0, 0, 0};       // too short
        cases[4] = '{-1, -1, -1, -1, 4'h0, -1, 1'b0, 0, 0};         // empty frame
        cases[5] = '{200, 229, 320, 349, 4'h9, -1, 1'b0, 0, 0};     // below threshold
        cases[6] = '{200, 229, 320, 349, 4'h9, 9, 1'b1, 214, 334};

        repeat (5) @(posedge iCLK);
        @(negedge iCLK);
        iRST = 1'b1;

        bus_read(wb_pkg::STATUS, rd);
        check_value("STATUS after reset", rd, 32'd0);
        bus_read(wb_pkg::ROW, rd);
        check_value("ROW after reset", rd, 32'd0);
        bus_read(wb_pkg::COL, rd);
        check_value("COL after reset", rd, 32'd0);
        bus_read(wb_pkg::FRAMES, rd);
        check_value("FRAMES after reset", rd, 32'd0);
        bus_read(wb_pkg::THRESH, rd);
        check_value("THRESH after reset", rd, 32'(`RED_THRESH_DEFAULT));

        for (int i = 0; i < N_CASES; i++) begin
            if (cases[i].thr_wr >= 0) begin
                bus_write(wb_pkg::THRESH, 32'(cases[i].thr_wr));
                bus_read(wb_pkg::THRESH, rd);
                check_value($sformatf("frame %0d THRESH", i), rd, 32'(cases[i].thr_wr));
            end
            stream_frame(i);
            wait_for_result(i, rd);
            check_value($sformatf("frame %0d present", i), {31'd0, rd[0]},
                        {31'd0, cases[i].exp_present});
            if (cases[i].exp_present) begin
                bus_read(wb_pkg::ROW, rd);
                check_value($sformatf("frame %0d ROW", i), rd, 32'(cases[i].exp_row));
                bus_read(wb_pkg::COL, rd);
                check_value($sformatf("frame %0d COL", i), rd, 32'(cases[i].exp_col));
            end
            bus_read(wb_pkg::STATUS, rd); // new was cleared by the poll
            check_value($sformatf("frame %0d new on second read", i), {31'd0, rd[1]}, 32'd0);
        end

        bus_read(wb_pkg::FRAMES, rd);
        check_value("FRAMES at end", rd, 32'(N_CASES));

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
